/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := scanline_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* logic/scanline_addr_pipe.sv */
`timescale 1ns/1ps

module scanline_addr_pipe #(
    parameter int SETTLE_CYCLES = 7 // >= pipeline depth
) (
    input  logic                     rst,        // clock
    input  logic                     mclk,       // async reset, active high
    input  scanline_pkg::scan_cfg_t  cfg,
    input  logic                     param_wr,
    input  logic                     restart,    // reload start point
    input  logic                     advance,    // transfer started, step position
    output scanline_pkg::xfer_desc_t desc,
    output logic                     desc_valid
);
    import scanline_pkg::*;

    localparam int MPY_BITS = FW_BITS + 1 + FH_BITS - 3; // 14 x 13 product

    logic [FW_BITS-1:0]   curr_x;        // window-relative x of next transfer
    logic [FH_BITS-1:0]   curr_y;
    logic [FW_BITS-1:0]   frame_x;       // stage 1
    logic [FH_BITS-1:0]   frame_y;
    logic [FH_BITS:0]     next_y;
    logic [FW_BITS:0]     row_left;      // bursts left in this window row
    logic [COL8_BITS:0]   mem_page_left; // stage 2, bursts to ddr3 page end
    logic [XFER_BITS:0]   lim_by_xfer;   // row_left clipped to 64
    logic [FH_BITS-4:0]   frame_y8_r;    // line index with bank bits dropped
    logic [FW_BITS:0]     full_width_r;
    logic [RC_BITS-1:0]   start_addr_r;
    logic [XFER_BITS:0]   num_r;         // stage 3
    logic [MPY_BITS-1:0]  mul_full;
    logic [RC_BITS-1:0]   mul_rslt;
    logic [RC_BITS-1:0]   line_start;    // stage 4
    logic                 last_in_row_r;
    logic [RC_BITS-1:0]   row_col_r;     // stage 5
    logic                 last_block_r;
    logic [SETTLE_CYCLES-1:0] settle_r;  // ones shifted in after a change

    assign mul_full = frame_y8_r * full_width_r; // upper bits dropped below

    // position in the window
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            curr_x <= '0;
            curr_y <= '0;
        end else if (restart) begin
            curr_x <= cfg.start_x;
            curr_y <= cfg.start_y;
        end else if (advance) begin
            curr_x <= desc.last_in_row ? '0 : curr_x + FW_BITS'(desc.num); // wrap to row start
            if (desc.last_in_row)
                curr_y <= next_y[FH_BITS-1:0];
        end
    end

    always_ff @(posedge rst) begin
        frame_x       <= curr_x + cfg.x0;
        frame_y       <= curr_y + cfg.y0;
        next_y        <= {1'b0, curr_y} + 1'b1;
        row_left      <= cfg.win_width - {1'b0, curr_x};
        mem_page_left <= 8'd128 - {1'b0, frame_x[COL8_BITS-1:0]};
        lim_by_xfer   <= (|row_left[FW_BITS:XFER_BITS]) ? 7'd64 : row_left[XFER_BITS:0];
        frame_y8_r    <= frame_y[FH_BITS-1:3];
        full_width_r  <= cfg.full_width;
        start_addr_r  <= cfg.start_addr;
        num_r         <= (mem_page_left < {1'b0, lim_by_xfer}) ?
                         mem_page_left[XFER_BITS:0] : lim_by_xfer; // page end wins if closer
        mul_rslt      <= mul_full[RC_BITS-1:0];
        line_start    <= start_addr_r + mul_rslt;
        last_in_row_r <= (row_left == {{(FW_BITS - XFER_BITS){1'b0}}, num_r});
        row_col_r     <= line_start + RC_BITS'(frame_x);
        last_block_r  <= (row_left == {{(FW_BITS - XFER_BITS){1'b0}}, num_r}) &&
                         (next_y == cfg.win_height);
    end

    // results trusted only after the pipeline has refilled
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk)
            settle_r <= '0;
        else if (restart || advance || param_wr)
            settle_r <= '0;
        else
            settle_r <= {settle_r[SETTLE_CYCLES-2:0], 1'b1};
    end

    assign desc_valid       = settle_r[SETTLE_CYCLES-1];
    assign desc.bank        = frame_y[2:0]; // 8 lines interleave over banks
    assign desc.row         = row_col_r[RC_BITS-1:COL8_BITS];
    assign desc.col         = row_col_r[COL8_BITS-1:0];
    assign desc.num         = num_r;
    assign desc.last_in_row = last_in_row_r;
    assign desc.last_block  = last_block_r;

    a_num_range: assert property (
        @(posedge rst) disable iff (mclk)
        desc_valid |-> (desc.num inside {[1:64]})
    );

endmodule

/* logic/scanline_pkg.sv */
package scanline_pkg;

    localparam int ROW_BITS  = 15; // ddr3 row address
    localparam int COL8_BITS = 7;  // column in 8-bursts, 128 per page
    localparam int RC_BITS   = 22; // {row, col8}
    localparam int XFER_BITS = 6;  // transfer length, 0 means 64
    localparam int FW_BITS   = 13; // frame/window width in bursts
    localparam int FH_BITS   = 16; // frame height in lines

    typedef enum logic [3:0] {
        REG_MODE         = 4'h0, // {extra_pages[1:0], enable, run}
        REG_START_ADDR   = 4'h2, // frame start in {row, col8}
        REG_FULL_WIDTH   = 4'h3, // padded line length in bursts
        REG_WINDOW_WH    = 4'h4, // low = width, high = height
        REG_WINDOW_X0Y0  = 4'h5, // low = left, high = top
        REG_WINDOW_START = 4'h6  // low = start x, high = start y
    } reg_addr_e;

    typedef struct packed {
        logic        we;   // single-cycle write strobe
        reg_addr_e   addr;
        logic [31:0] data;
    } cmd_wr_t;

    typedef struct packed {
        logic [RC_BITS-1:0] start_addr;
        logic [FW_BITS:0]   full_width; // carry bit set when written as 0
        logic [FW_BITS:0]   win_width;
        logic [FH_BITS:0]   win_height;
        logic [FW_BITS-1:0] x0;
        logic [FH_BITS-1:0] y0;
        logic [FW_BITS-1:0] start_x;    // relative to window
        logic [FH_BITS-1:0] start_y;
    } scan_cfg_t;

    typedef struct packed {
        logic [2:0]           bank;
        logic [ROW_BITS-1:0]  row;
        logic [COL8_BITS-1:0] col;
        logic [XFER_BITS:0]   num;         // 1..64 bursts
        logic                 last_in_row;
        logic                 last_block;  // last transfer of the window
    } xfer_desc_t;

    typedef struct packed {
        logic [1:0] extra_pages; // credits held back from the buffer
        logic       enable;
        logic       run;         // low keeps the channel in reset
    } scan_mode_t;

endpackage

/* logic/scanline_regs.sv */
`timescale 1ns/1ps

module scanline_regs (
    input  logic                     rst,      // clock
    input  logic                     mclk,     // active-high async reset
    input  scanline_pkg::cmd_wr_t    cmd,
    output scanline_pkg::scan_cfg_t  cfg,
    output scanline_pkg::scan_mode_t mode,
    output logic                     param_wr  // any register changed
);
    import scanline_pkg::*;

    logic lo_zero;    // low width field is 0
    logic hi_zero;    // full upper halfword is 0

    assign lo_zero    = (cmd.data[FW_BITS-1:0] == '0);
    assign hi_zero    = (cmd.data[FH_BITS+15:16] == '0);

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cfg      <= '0;
            mode     <= '0; // run low holds the channel in reset
            param_wr <= 1'b0;
        end else begin
            param_wr <= cmd.we; // lines up with the updated fields
            if (cmd.we) begin
                case (cmd.addr)
                    REG_MODE: begin
                        mode <= scan_mode_t'(cmd.data[3:0]);
                    end
                    REG_START_ADDR: begin
                        cfg.start_addr <= cmd.data[RC_BITS-1:0];
                    end
                    REG_FULL_WIDTH: begin
                        cfg.full_width <= {lo_zero, cmd.data[FW_BITS-1:0]}; // 0 -> 'h2000
                    end
                    REG_WINDOW_WH: begin
                        cfg.win_width  <= {lo_zero, cmd.data[FW_BITS-1:0]};
                        cfg.win_height <= {hi_zero, cmd.data[FH_BITS+15:16]}; // 0 -> 'h10000
                    end
                    REG_WINDOW_X0Y0: begin
                        cfg.x0 <= cmd.data[FW_BITS-1:0];
                        cfg.y0 <= cmd.data[FH_BITS+15:16];
                    end
                    REG_WINDOW_START: begin
                        cfg.start_x <= cmd.data[FW_BITS-1:0];
                        cfg.start_y <= cmd.data[FH_BITS+15:16];
                    end
                    default: begin
                        // nothing loaded for unused addresses
                    end
                endcase
            end
        end
    end

    // host side must only address implemented registers
    a_cmd_addr_legal: assert property (
        @(posedge rst) disable iff (mclk)
        cmd.we |-> (cmd.addr inside {REG_MODE, REG_START_ADDR, REG_FULL_WIDTH,
                                     REG_WINDOW_WH, REG_WINDOW_X0Y0, REG_WINDOW_START})
    );

endmodule

/* logic/scanline_rw.sv */
`timescale 1ns/1ps

module scanline_rw #(
    parameter int SETTLE_CYCLES = 7 // cycles before a descriptor is trusted
) (
    input  logic                                rst,          // clock
    input  logic                                mclk,         // async reset, active high
    input  scanline_pkg::cmd_wr_t               cmd,
    input  logic                                frame_start,
    input  logic                                next_page,
    input  logic                                xfer_grant,
    input  logic                                xfer_done,
    output logic                                frame_done,
    output logic                                xfer_want,
    output logic                                xfer_need,
    output logic                                xfer_start,
    output logic [2:0]                          xfer_bank,
    output logic [scanline_pkg::ROW_BITS-1:0]   xfer_row,
    output logic [scanline_pkg::COL8_BITS-1:0]  xfer_col,
    output logic [scanline_pkg::XFER_BITS-1:0]  xfer_num128,  // 0 means 64
    output logic                                xfer_reset_page
);
    import scanline_pkg::*;

    scan_cfg_t  cfg;
    scan_mode_t mode;
    xfer_desc_t desc;
    logic       param_wr;
    logic       desc_valid;
    logic       restart;
    logic       advance;

    scanline_regs u_regs (
        .rst      (rst),
        .mclk     (mclk),
        .cmd      (cmd),
        .cfg      (cfg),
        .mode     (mode),
        .param_wr (param_wr)
    );

    scanline_addr_pipe #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_addr_pipe (
        .rst        (rst),
        .mclk       (mclk),
        .cfg        (cfg),
        .param_wr   (param_wr),
        .restart    (restart),
        .advance    (advance),
        .desc       (desc),
        .desc_valid (desc_valid)
    );

    scanline_xfer_ctrl u_xfer_ctrl (
        .rst             (rst),
        .mclk            (mclk),
        .mode            (mode),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .xfer_grant      (xfer_grant),
        .xfer_done       (xfer_done),
        .desc            (desc),
        .desc_valid      (desc_valid),
        .restart         (restart),
        .advance         (advance),
        .xfer_want       (xfer_want),
        .xfer_need       (xfer_need),
        .xfer_start      (xfer_start),
        .frame_done      (frame_done),
        .xfer_reset_page (xfer_reset_page)
    );

    assign xfer_bank   = desc.bank;
    assign xfer_row    = desc.row;
    assign xfer_col    = desc.col;
    assign xfer_num128 = desc.num[XFER_BITS-1:0]; // 64 wraps to 0

endmodule

/* logic/scanline_xfer_ctrl.sv */
`timescale 1ns/1ps

module scanline_xfer_ctrl (
    input  logic                     rst,        // clock
    input  logic                     mclk,       // active-high async reset
    input  scanline_pkg::scan_mode_t mode,
    input  logic                     frame_start,
    input  logic                     next_page,  // buffer page consumed
    input  logic                     xfer_grant,
    input  logic                     xfer_done,
    input  scanline_pkg::xfer_desc_t desc,
    input  logic                     desc_valid,
    output logic                     restart,
    output logic                     advance,
    output logic                     xfer_want,
    output logic                     xfer_need,
    output logic                     xfer_start,
    output logic                     frame_done,
    output logic                     xfer_reset_page
);
    localparam int PEND_BITS = 3; // up to 4 outstanding with 4 credits

    logic                 chn_en;       // new requests allowed
    logic                 chn_rst;      // channel held in reset
    logic                 busy_r;
    logic                 want_r;
    logic                 need_r;
    logic                 start_r;
    logic                 done_d;       // xfer_done one cycle late
    logic                 frame_done_r;
    logic                 last_block;   // final transfer already issued
    logic                 reset_page_r;
    logic [2:0]           page_cntr;    // free buffer pages
    logic [PEND_BITS-1:0] pending;      // started and not yet done
    logic                 pre_want;

    assign chn_en  = mode.enable && mode.run;
    assign chn_rst = !mode.run;
    assign pre_want = chn_en && busy_r && !want_r && !start_r && desc_valid && !last_block;

    assign restart         = chn_rst || frame_start;
    assign advance         = start_r;
    assign xfer_want       = want_r;
    assign xfer_need       = need_r;
    assign xfer_start      = start_r;
    assign frame_done      = frame_done_r;
    assign xfer_reset_page = reset_page_r;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            busy_r       <= 1'b0;
            want_r       <= 1'b0;
            need_r       <= 1'b0;
            start_r      <= 1'b0;
            done_d       <= 1'b0;
            frame_done_r <= 1'b0;
            reset_page_r <= 1'b0;
        end else begin
            start_r      <= xfer_grant && !chn_rst; // one cycle after grant
            done_d       <= xfer_done;
            reset_page_r <= chn_rst;

            if (chn_rst)
                busy_r <= 1'b0;
            else if (frame_start)
                busy_r <= 1'b1;
            else if (frame_done_r)
                busy_r <= 1'b0;

            if (chn_rst || xfer_grant)
                want_r <= 1'b0;
            else if (pre_want && (page_cntr > {1'b0, mode.extra_pages}))
                want_r <= 1'b1; // credits beyond the reserve

            if (chn_rst || xfer_grant)
                need_r <= 1'b0;
            else if (pre_want && (page_cntr > {1'b0, mode.extra_pages}))
                need_r <= (page_cntr >= 3'd3); // urgent when the buffer is nearly empty

            if (chn_rst || frame_start)
                frame_done_r <= 1'b0;
            else if (busy_r && last_block && done_d && (pending == '0))
                frame_done_r <= 1'b1; // sticky until next frame
        end
    end

    // page credits, pending count, last block
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            page_cntr  <= '0;
            pending    <= '0;
            last_block <= 1'b0;
        end else begin
            if (frame_start)
                page_cntr <= 3'd4; // whole buffer free
            else if (start_r && !next_page)
                page_cntr <= page_cntr - 1'b1;
            else if (!start_r && next_page)
                page_cntr <= page_cntr + 1'b1;

            if (chn_rst || !busy_r)
                pending <= '0;
            else if (start_r && !xfer_done)
                pending <= pending + 1'b1;
            else if (!start_r && xfer_done)
                pending <= pending - 1'b1;

            if (chn_rst || !busy_r)
                last_block <= 1'b0;
            else if (start_r)
                last_block <= desc.last_block; // desc still holds the issued transfer
        end
    end

    a_grant_needs_want: assert property (
        @(posedge rst) disable iff (mclk)
        xfer_grant |-> want_r
    );

    // done from the memory side must match an earlier start
    a_pending_no_underflow: assert property (
        @(posedge rst) disable iff (mclk)
        (xfer_done && !start_r && busy_r && !chn_rst) |-> (pending != '0)
    );

endmodule

/* project.f */
logic/scanline_pkg.sv
logic/scanline_regs.sv
logic/scanline_addr_pipe.sv
logic/scanline_xfer_ctrl.sv
logic/scanline_rw.sv
sim/scanline_tb.sv

/* sim/scanline_tb.sv */
`timescale 1ns/1ps

module scanline_tb;
    import scanline_pkg::*;

    localparam int N_CFG = 5;

    typedef struct packed {
        logic [21:0] start_addr;
        logic [15:0] full_width;
        logic [15:0] win_w;
        logic [15:0] win_h;
        logic [15:0] x0;
        logic [15:0] y0;
        logic [15:0] sx;          // start point relative to the window
        logic [15:0] sy;
        logic [1:0]  extra;       // reserved page credits
        logic [7:0]  n_xfers;     // transfers in the frame
    } frame_cfg_t;

    logic                 rst;    // clock
    logic                 mclk;   // reset
    cmd_wr_t              cmd;
    logic                 frame_start;
    logic                 next_page;
    logic                 xfer_grant;
    logic                 xfer_done;
    logic                 frame_done;
    logic                 xfer_want;
    logic                 xfer_need;
    logic                 xfer_start;
    logic [2:0]           xfer_bank;
    logic [ROW_BITS-1:0]  xfer_row;
    logic [COL8_BITS-1:0] xfer_col;
    logic [XFER_BITS-1:0] xfer_num128;
    logic                 xfer_reset_page;

    frame_cfg_t  cfg_table [N_CFG];
    logic [30:0] exp_q [$];       // {bank, row, col, num mod 64}
    int          done_due [$];    // cycle numbers of pending xfer_done pulses
    string       test_name;
    logic [31:0] lcg_state;
    int cycle_no, credits, cur_extra, want_age, np_owed, last_done_cycle;
    int n_started, n_done;
    logic prev_want, prev_start, prev_done, np_hold;

    scanline_rw #(
        .SETTLE_CYCLES (7)
    ) u_scanline_rw (
        .rst             (rst),
        .mclk            (mclk),
        .cmd             (cmd),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .xfer_grant      (xfer_grant),
        .xfer_done       (xfer_done),
        .frame_done      (frame_done),
        .xfer_want       (xfer_want),
        .xfer_need       (xfer_need),
        .xfer_start      (xfer_start),
        .xfer_bank       (xfer_bank),
        .xfer_row        (xfer_row),
        .xfer_col        (xfer_col),
        .xfer_num128     (xfer_num128),
        .xfer_reset_page (xfer_reset_page)
    );

    initial begin
        rst = 1'b0;
        forever #2 rst = ~rst; // 4 ns period
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_value(input string what, input logic [63:0] expv, input logic [63:0] actv);
        $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expv, actv);
        abort_run();
    endtask

    task automatic fail_msg(input string what);
        $display("ERROR %s: %s", test_name, what);
        abort_run();
    endtask

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]);
    endfunction

    // reference walk of the window in scan-line order
    task automatic build_expected(input frame_cfg_t c);
        int cx, cy, fx, fy, left, num, rc;
        bit fin;
        exp_q.delete();
        cx = int'(c.sx);
        cy = int'(c.sy);
        fin = 1'b0;
        while (!fin) begin
            fx = (int'(c.x0) + cx) % 8192;
            fy = (int'(c.y0) + cy) % 65536;
            left = int'(c.win_w) - cx;
            num = (left < 64) ? left : 64;
            if (128 - fx % 128 < num)
                num = 128 - fx % 128;                  // stop at ddr3 page end
            rc = (int'(c.start_addr) + (fy / 8) * int'(c.full_width) + fx) % (1 << 22);
            exp_q.push_back({3'(fy % 8), 15'(rc / 128), 7'(rc % 128), 6'(num % 64)});
            if (num == left && cy + 1 == int'(c.win_h))
                fin = 1'b1;
            else if (num == left) begin
                cx = 0;
                cy++;
            end else
                cx += num;
        end
    endtask

    task automatic schedule_done();
        int due;
        due = cycle_no + 1 + next_rand() % 6;
        if (done_due.size() > 0 && due <= done_due[$])
            due = done_due[$] + 1;                     // one done per cycle and in order
        done_due.push_back(due);
    endtask

    // samples at edge + 1 ns and checks before acting as arbiter and memory
    task automatic run_cycle();
        int credits_used;
        logic [30:0] act;
        @(posedge rst);
        #1;
        cycle_no++;
        credits_used = credits;                        // page count the DUT saw at this edge
        if (frame_start)
            credits = 4;
        else
            credits = credits - int'(prev_start) + int'(next_page);
        if (xfer_want && !prev_want) begin
            assert (xfer_need == (credits_used >= 3)) else
                fail_value("xfer_need with want", 64'(credits_used >= 3), 64'(xfer_need));
            assert (credits_used > cur_extra) else
                fail_msg("xfer_want rose without credits beyond the reserve");
        end
        assert (xfer_want || !xfer_need) else fail_msg("xfer_need high without xfer_want");
        if (xfer_start) begin
            act = {xfer_bank, xfer_row, xfer_col, xfer_num128};
            assert (n_started < exp_q.size()) else
                fail_msg("transfer started past the end of the window");
            assert (act == exp_q[n_started]) else
                fail_value("descriptor", 64'(exp_q[n_started]), 64'(act));
            n_started++;
            schedule_done();
        end
        if (frame_done && !prev_done) begin
            assert (n_started == exp_q.size() && n_done == exp_q.size()) else
                fail_msg("frame_done rose before all transfers completed");
            assert (cycle_no - last_done_cycle == 2) else
                fail_value("frame_done delay", 64'd2, 64'(cycle_no - last_done_cycle));
        end
        prev_want  = xfer_want;
        prev_start = xfer_start;
        prev_done  = frame_done;
        want_age   = xfer_want ? want_age + 1 : 0;
        xfer_grant = xfer_want && (want_age == 2);     // grant 2 cycles after want
        next_page  = !np_hold && (np_owed > 0);        // pages released one per cycle
        if (next_page)
            np_owed--;
        xfer_done = 1'b0;
        if (done_due.size() > 0 && done_due[0] <= cycle_no) begin
            xfer_done = 1'b1;
            void'(done_due.pop_front());
            n_done++;
            np_owed++;
            last_done_cycle = cycle_no;
        end
    endtask

    task automatic write_reg(input reg_addr_e a, input logic [31:0] d);
        cmd.we   = 1'b1;
        cmd.addr = a;
        cmd.data = d;
        run_cycle();
        cmd.we = 1'b0;
    endtask

    task automatic program_frame(input frame_cfg_t c, input logic [1:0] extra);
        write_reg(REG_MODE, {28'd0, extra, 2'b11});     // enable and run
        write_reg(REG_START_ADDR, {10'd0, c.start_addr});
        write_reg(REG_FULL_WIDTH, {16'd0, c.full_width});
        write_reg(REG_WINDOW_WH, {c.win_h, c.win_w});
        write_reg(REG_WINDOW_X0Y0, {c.y0, c.x0});
        write_reg(REG_WINDOW_START, {c.sy, c.sx});
        cur_extra = int'(extra);
        build_expected(c);
    endtask

    task automatic start_frame();
        n_started   = 0;
        n_done      = 0;
        frame_start = 1'b1;
        run_cycle();
        frame_start = 1'b0;
        assert (!frame_done) else fail_msg("frame_done not cleared by frame_start");
        assert (!xfer_reset_page) else fail_msg("xfer_reset_page active while the channel runs");
    endtask

    task automatic wait_starts(input int target, input int limit);
        int t;
        t = 0;
        while (n_started < target) begin
            if (t == limit) begin
                $display("timeout waiting for %0d transfer starts in %s", target, test_name);
                abort_run();
            end
            run_cycle();
            t++;
        end
    endtask

    task automatic wait_frame_done(input int limit);
        int t;
        t = 0;
        while (!frame_done) begin
            if (t == limit) begin
                $display("timeout waiting for frame_done in %s", test_name);
                abort_run();
            end
            run_cycle();
            t++;
        end
    endtask

    task automatic wait_reset_page(input int limit);
        int t;
        t = 0;
        while (!xfer_reset_page) begin
            if (t == limit) begin
                $display("timeout waiting for xfer_reset_page in %s", test_name);
                abort_run();
            end
            run_cycle();
            t++;
        end
    endtask

    task automatic watch_no_want(input int cycles);
        repeat (cycles) begin
            run_cycle();
            assert (!xfer_want) else fail_msg("xfer_want raised while it must stay low");
        end
    endtask

    task automatic watch_done_held(input int cycles);
        repeat (cycles) begin
            run_cycle();
            assert (frame_done) else fail_msg("frame_done dropped before the next frame_start");
        end
    endtask

    task automatic watch_aborted(input int cycles);
        repeat (cycles) begin
            run_cycle();
            assert (!xfer_start) else fail_msg("transfer started after channel reset");
            assert (!frame_done) else fail_msg("frame_done raised for an aborted frame");
        end
    endtask

    initial begin
        cmd         = '0;
        frame_start = 1'b0;
        next_page   = 1'b0;
        xfer_grant  = 1'b0;
        xfer_done   = 1'b0;
        mclk        = 1'b1;
        lcg_state   = 32'd8;                           // fixed seed
        cycle_no        = 0;
        credits         = 0;
        cur_extra       = 0;
        want_age        = 0;
        np_owed         = 0;
        last_done_cycle = 0;
        n_started       = 0;
        n_done          = 0;
        prev_want       = 1'b0;
        prev_start      = 1'b0;
        prev_done       = 1'b0;
        np_hold         = 1'b0;
        test_name = "reset";
        // fields in order start_addr full win_w win_h x0 y0 sx sy extra n_xfers
        cfg_table[0] = '{22'h000100, 16'd200, 16'd100, 16'd3, 16'd10, 16'd5,
                         16'd0, 16'd0, 2'd0, 8'd6};
        cfg_table[1] = '{22'h012345, 16'd300, 16'd150, 16'd4, 16'd100, 16'd13,
                         16'd20, 16'd1, 2'd1, 8'd9};
        cfg_table[2] = '{22'h3fffe0, 16'd64, 16'd10, 16'd9, 16'd0, 16'd0,
                         16'd0, 16'd0, 2'd2, 8'd9};
        cfg_table[3] = '{22'h000000, 16'd40, 16'd1, 16'd2, 16'd127, 16'd7,
                         16'd0, 16'd0, 2'd0, 8'd2};
        cfg_table[4] = '{22'h001000, 16'd400, 16'd200, 16'd1, 16'd50, 16'd0,
                         16'd0, 16'd0, 2'd1, 8'd4};

        repeat (3) @(posedge rst);
        #1;
        mclk = 1'b0;
        run_cycle();
        assert (xfer_reset_page) else fail_msg("channel not held in reset after power-up");
        assert (!xfer_want && !xfer_need && !xfer_start && !frame_done) else
            fail_msg("transfer outputs active after reset");

        for (int i = 0; i < N_CFG; i++) begin
            test_name = $sformatf("table[%0d]", i);
            program_frame(cfg_table[i], cfg_table[i].extra);
            assert (exp_q.size() == int'(cfg_table[i].n_xfers)) else
                fail_value("model count", 64'(cfg_table[i].n_xfers), 64'(exp_q.size()));
            start_frame();
            wait_frame_done(3000);
            watch_done_held(6);
        end

        // next_page withheld until the 4 initial credits run out
        test_name = "page credits";
        program_frame(cfg_table[0], 2'd0);
        np_hold = 1'b1;
        start_frame();
        wait_starts(4, 400);
        watch_no_want(60);
        assert (n_started == 4) else fail_value("starts without pages", 64'd4, 64'(n_started));
        np_hold = 1'b0;
        wait_frame_done(3000);
        watch_done_held(4);

        // three pages held back so only a full buffer allows a request
        test_name = "reserve";
        program_frame(cfg_table[0], 2'd3);
        np_hold = 1'b1;
        start_frame();
        wait_starts(1, 200);
        watch_no_want(40);
        assert (n_started == 1) else fail_value("starts with reserve", 64'd1, 64'(n_started));
        np_hold = 1'b0;
        wait_frame_done(4000);
        watch_done_held(4);

        test_name = "channel control";
        cur_extra = 0;
        write_reg(REG_MODE, 32'h1);                    // run without enable
        start_frame();
        watch_no_want(40);
        write_reg(REG_MODE, 32'h3);
        wait_starts(2, 300);
        write_reg(REG_MODE, 32'h0);                    // run low aborts the frame
        wait_reset_page(10);
        watch_aborted(40);

        $display("Simulation passed");
        $finish;
    end

endmodule
